/* hdl/cpuPorts.sv */
`timescale 1ns/1ns

`include "ula_config.svh"

module cpuPorts
   import ulaPkg::*;
(
   input  logic        clk7,
   input  logic        rst_n,
   input  logic [15:0] a,
   input  logic        iorqN,
   input  logic        rdN,
   input  logic        wrN,
   input  byteT        din,
   output byteT        dout,
   input  logic        ear,
   input  logic [4:0]  kbd,
   output colour3      border,
   output logic        mic,
   output logic        spk
);

   logic portSel;
   logic portWrite;
   logic portRead;

   //////////////////////////////////////////////////////////////////////
   // Port decode
   //////////////////////////////////////////////////////////////////////

   // Any even port answers, except the one owned by the MMU
   assign portSel   = !a[0] && (a[7:0] != `ULA_PORT_MMU);
   assign portWrite = !iorqN && !wrN && portSel;
   assign portRead  = !iorqN && !rdN && portSel;

   //////////////////////////////////////////////////////////////////////
   // Output registers
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         border <= `ULA_BORDER_RESET;
         mic    <= 1'b0;
         spk    <= 1'b0;
      end else if (portWrite) begin
         border <= din[2:0];
         mic    <= din[3];
         spk    <= din[4];
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Read data
   //////////////////////////////////////////////////////////////////////

   // EAR input sees the speaker output through the analogue stage
   always_comb begin
      if (portRead) begin
         dout = {1'b1, ear ^ spk, 1'b1, kbd};
      end else begin
         // Idle bus pulls high
         dout = 8'hFF;
      end
   end

endmodule

/* hdl/fetchControl.sv */
`timescale 1ns/1ns

`include "ula_config.svh"

module fetchControl
   import ulaPkg::*;
(
   input  logic    clk7,
   input  logic    rst_n,
   input  hCount   hc,
   input  vCount   vc,
   output logic    bitmapLoad,
   output logic    attrLoad,
   output logic    serialLoad,
   output logic    attrOutLoad,
   output logic    videoEnable,
   output vramAddr va
);

   logic    inPaper;
   logic    attrSel;
   colIndex colAddr;

   //////////////////////////////////////////////////////////////////////
   // Fetch window
   //////////////////////////////////////////////////////////////////////

   // Fetches happen over the 256 paper clocks of lines 0 to 191
   assign inPaper = (vc < `ULA_PAPER_H) && (hc < `ULA_PAPER_W);

   // Two bitmap and two attribute reads per 16 clocks
   always_comb begin
      bitmapLoad = 1'b0;
      attrLoad   = 1'b0;
      attrSel    = 1'b0;
      if (inPaper) begin
         case (hc[3:0])
            4'd9, 4'd13: begin
               bitmapLoad = 1'b1;
            end
            4'd10, 4'd14: begin
               attrSel = 1'b1;
            end
            4'd11, 4'd15: begin
               attrSel  = 1'b1;
               attrLoad = 1'b1;
            end
            default: begin
               attrSel = 1'b0;
            end
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Output strobes
   //////////////////////////////////////////////////////////////////////

   // Displayed paper lags the fetch by 8 clocks
   assign videoEnable = (vc < `ULA_PAPER_H) && (hc >= 9'd8) &&
                        (hc < (`ULA_PAPER_W + 8));

   // Attribute output refreshes every 8 clocks, paper or border
   assign attrOutLoad = (hc[2:0] == 3'd4);
   assign serialLoad  = videoEnable && attrOutLoad;

   //////////////////////////////////////////////////////////////////////
   // Column register and address
   //////////////////////////////////////////////////////////////////////

   // Latched mid-cell so the address holds steady across each fetch pair
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         colAddr <= '0;
      end else if (hc[2:0] == 3'd3) begin
         colAddr <= hc[7:3];
      end
   end

   // Bitmap form is the default outside a fetch
   assign va = attrSel ? {1'b0, 3'b110, vc[7:3], colAddr} :
                         {1'b0, vc[7:6], vc[2:0], vc[5:3], colAddr};

endmodule

/* hdl/pixelPipe.sv */
`timescale 1ns/1ns

`include "ula_config.svh"

module pixelPipe
   import ulaPkg::*;
(
   input  logic   clk7,
   input  logic   rst_n,
   input  hCount  hc,
   input  vCount  vc,
   input  byteT   vramData,
   input  colour3 border,
   input  logic   bitmapLoad,
   input  logic   attrLoad,
   input  logic   serialLoad,
   input  logic   attrOutLoad,
   input  logic   videoEnable,
   output colour3 r,
   output colour3 g,
   output colour3 b
);

   byteT      bitmapData;
   byteT      attrData;
   byteT      shiftReg;
   byteT      attrOut;
   logic [`ULA_FLASH_BITS-1:0] flashCnt;
   logic      pixel;
   igrbColour igrb;
   colour3    level;
   logic [8:0] grb9;

   //////////////////////////////////////////////////////////////////////
   // Data capture and serializer
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         bitmapData <= '0;
         attrData   <= '0;
      end else begin
         if (bitmapLoad) begin
            bitmapData <= vramData;
         end
         if (attrLoad) begin
            attrData <= vramData;
         end
      end
   end

   // MSB first, zeros shifted in so the border shows paper
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         shiftReg <= '0;
      end else if (serialLoad) begin
         shiftReg <= bitmapData;
      end else begin
         shiftReg <= {shiftReg[6:0], 1'b0};
      end
   end

   // Border cells: ink and paper both the border colour, no bright or flash
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         attrOut <= '0;
      end else if (attrOutLoad) begin
         attrOut <= videoEnable ? attrData : {2'b00, border, border};
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Flash and colour select
   //////////////////////////////////////////////////////////////////////

   // Counts frames at the start of vertical sync
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         flashCnt <= '0;
      end else if ((vc == `ULA_VSYNC_START) && (hc == 9'd0)) begin
         flashCnt <= flashCnt + 1'b1;
      end
   end

   assign pixel = shiftReg[7] ^ (attrOut[7] & flashCnt[`ULA_FLASH_BITS-1]);
   assign igrb  = {attrOut[6], (pixel ? attrOut[2:0] : attrOut[5:3])};

   //////////////////////////////////////////////////////////////////////
   // Palette
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      level = igrb[3] ? `ULA_LEVEL_FULL : `ULA_LEVEL_HALF;
      case (igrb[2:0])
         3'd0: grb9 = {3'd0,  3'd0,  3'd0};
         3'd1: grb9 = {3'd0,  3'd0,  level};
         3'd2: grb9 = {3'd0,  level, 3'd0};
         3'd3: grb9 = {3'd0,  level, level};
         3'd4: grb9 = {level, 3'd0,  3'd0};
         3'd5: grb9 = {level, 3'd0,  level};
         3'd6: grb9 = {level, level, 3'd0};
         default: grb9 = {level, level, level};
      endcase
   end

   assign g = grb9[8:6];
   assign r = grb9[5:3];
   assign b = grb9[2:0];

endmodule

/* hdl/ulaPkg.sv */
package ulaPkg;

   // Raster position
   typedef logic [8:0] hCount;
   typedef logic [8:0] vCount;

   // 16 KB video RAM
   typedef logic [13:0] vramAddr;

   // CPU and VRAM data byte
   typedef logic [7:0] byteT;

   // One colour channel, or a GRB index as found in the attribute
   typedef logic [2:0] colour3;

   // Bright in bit 3, then G, R, B
   typedef logic [3:0] igrbColour;

   // Character column on a paper line, 0 to 31
   typedef logic [4:0] colIndex;

endpackage

/* hdl/ulaTop.sv */
`timescale 1ns/1ns

module ulaTop
   import ulaPkg::*;
(
   input  logic        clk7,
   input  logic        rst_n,
   input  logic [15:0] a,
   input  logic        iorqN,
   input  logic        rdN,
   input  logic        wrN,
   input  byteT        din,
   output byteT        dout,
   output vramAddr     va,
   input  byteT        vramData,
   input  logic        ear,
   input  logic [4:0]  kbd,
   output logic        mic,
   output logic        spk,
   output colour3      r,
   output colour3      g,
   output colour3      b,
   output logic        hsync,
   output logic        vsync,
   output logic        intN
);

   hCount  hc;
   vCount  vc;
   colour3 border;
   logic   bitmapLoad;
   logic   attrLoad;
   logic   serialLoad;
   logic   attrOutLoad;
   logic   videoEnable;

   videoTiming timing (
      .clk7  (clk7),
      .rst_n (rst_n),
      .hc    (hc),
      .vc    (vc),
      .hsync (hsync),
      .vsync (vsync),
      .intN  (intN)
   );

   fetchControl fetch (
      .clk7        (clk7),
      .rst_n       (rst_n),
      .hc          (hc),
      .vc          (vc),
      .bitmapLoad  (bitmapLoad),
      .attrLoad    (attrLoad),
      .serialLoad  (serialLoad),
      .attrOutLoad (attrOutLoad),
      .videoEnable (videoEnable),
      .va          (va)
   );

   pixelPipe pixels (
      .clk7        (clk7),
      .rst_n       (rst_n),
      .hc          (hc),
      .vc          (vc),
      .vramData    (vramData),
      .border      (border),
      .bitmapLoad  (bitmapLoad),
      .attrLoad    (attrLoad),
      .serialLoad  (serialLoad),
      .attrOutLoad (attrOutLoad),
      .videoEnable (videoEnable),
      .r           (r),
      .g           (g),
      .b           (b)
   );

   cpuPorts ports (
      .clk7   (clk7),
      .rst_n  (rst_n),
      .a      (a),
      .iorqN  (iorqN),
      .rdN    (rdN),
      .wrN    (wrN),
      .din    (din),
      .dout   (dout),
      .ear    (ear),
      .kbd    (kbd),
      .border (border),
      .mic    (mic),
      .spk    (spk)
   );

endmodule

/* hdl/ula_config.svh */
`ifndef ULA_CONFIG_SVH
`define ULA_CONFIG_SVH

// Raster geometry of the 48K frame, in pixel clocks and lines
`define ULA_H_TOTAL       448
`define ULA_V_TOTAL       312
`define ULA_PAPER_W       256
`define ULA_PAPER_H       192

// Sync positions, active low
`define ULA_HSYNC_START   344
`define ULA_HSYNC_LEN     32
`define ULA_VSYNC_START   248
`define ULA_VSYNC_LEN     4

// Frame interrupt width on the first vsync line
`define ULA_INT_LEN       32

// Flash toggles every 16 frames, so the top bit of a 5-bit count
`define ULA_FLASH_BITS    5

// Red border out of reset
`define ULA_BORDER_RESET  3'd2

// Channel levels for normal and bright colours
`define ULA_LEVEL_HALF    3'd5
`define ULA_LEVEL_FULL    3'd7

// Even port left to the MMU
`define ULA_PORT_MMU      8'hF4

`endif

/* hdl/videoTiming.sv */
`timescale 1ns/1ns

`include "ula_config.svh"

module videoTiming
   import ulaPkg::*;
(
   input  logic  clk7,
   input  logic  rst_n,
   output hCount hc,
   output vCount vc,
   output logic  hsync,
   output logic  vsync,
   output logic  intN
);

   logic lineEnd;
   logic frameEnd;

   //////////////////////////////////////////////////////////////////////
   // Raster counters
   //////////////////////////////////////////////////////////////////////

   assign lineEnd  = (hc == (`ULA_H_TOTAL - 1));
   assign frameEnd = (vc == (`ULA_V_TOTAL - 1));

   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         hc <= '0;
      end else if (lineEnd) begin
         hc <= '0;
      end else begin
         hc <= hc + 1'b1;
      end
   end

   // Line counter steps once per wrap of hc
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         vc <= '0;
      end else if (lineEnd) begin
         if (frameEnd) begin
            vc <= '0;
         end else begin
            vc <= vc + 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Sync and interrupt decode
   //////////////////////////////////////////////////////////////////////

   // Low from hc 344 through 375
   assign hsync = !((hc >= `ULA_HSYNC_START) &&
                    (hc < (`ULA_HSYNC_START + `ULA_HSYNC_LEN)));

   // Low on lines 248 through 251
   assign vsync = !((vc >= `ULA_VSYNC_START) &&
                    (vc < (`ULA_VSYNC_START + `ULA_VSYNC_LEN)));

   // One pulse per frame, at the start of the first vsync line
   assign intN = !((vc == `ULA_VSYNC_START) && (hc < `ULA_INT_LEN));

endmodule

/* sim.f */
+incdir+hdl
hdl/ulaPkg.sv
hdl/videoTiming.sv
hdl/fetchControl.sv
hdl/pixelPipe.sv
hdl/cpuPorts.sv
hdl/ulaTop.sv
tests/ula_checker.sv
tests/ulaTb.sv

/* tests/ulaTb.sv */
`timescale 1ns/1ns

`include "ula_config.svh"

module ulaTb;
   import ulaPkg::*;

   localparam int FRAMES     = 34;
   localparam int CYCLE_CAP  = 5000000;

   logic        clk7 = 1'b0;
   logic        rst_n;
   logic [15:0] a;
   logic        iorqN;
   logic        rdN;
   logic        wrN;
   byteT        din;
   byteT        dout;
   vramAddr     va;
   byteT        vramData;
   logic        ear;
   logic [4:0]  kbd;
   logic        mic;
   logic        spk;
   colour3      r;
   colour3      g;
   colour3      b;
   logic        hsync;
   logic        vsync;
   logic        intN;

   integer      seed = 32'h93f0;
   int          cycles = 0;
   int          frameCount = 0;
   logic        prevIntN = 1'b1;
   int          sinceReset;
   int          lineNo;
   int          pick;
   logic [15:0] addr;

   ulaTop UUT (.*);

   bind ulaTop ulaChecker chk (.*);

   always #4 clk7 = ~clk7;

   // Video RAM model with F0 bitmap bytes and attributes taken from the address
   always_comb begin
      if (va[12:10] == 3'b110) begin
         vramData = {va[4], va[3], va[7:5], va[2:0]};
      end else begin
         vramData = 8'hF0;
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // Frame count, failure watch and timeout
   ///////////////////////////////////////////////////////////////////////

   always @(negedge clk7) begin
      if (rst_n && prevIntN && !intN) begin
         frameCount++;
      end
      prevIntN <= intN;
   end

   always @(negedge clk7) begin
      if (UUT.chk.failCount != 0) begin
         $display("error: test %s expected %h actual %h", UUT.chk.failTest,
                  UUT.chk.failExp, UUT.chk.failAct);
         $display("Simulation FAILED");
         $fatal(1, "assertion failed");
      end
   end

   always @(posedge clk7) begin
      cycles++;
      if (cycles >= CYCLE_CAP) begin
         $display("run did not finish in time after %0d cycles", cycles);
         $display("Simulation FAILED");
         $fatal(1, "timeout");
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // Stimulus
   ///////////////////////////////////////////////////////////////////////

   initial begin
      rst_n = 1'b0;
      a     = 16'h0000;
      iorqN = 1'b1;
      rdN   = 1'b1;
      wrN   = 1'b1;
      din   = 8'h00;
      ear   = 1'b0;
      kbd   = 5'h1F;
      repeat (16) @(posedge clk7);
      rst_n <= 1'b1;

      // MMU port write must leave everything alone
      @(posedge clk7);
      a     <= 16'h12F4;
      din   <= 8'h1F;
      iorqN <= 1'b0;
      wrN   <= 1'b0;
      sinceReset = 1;

      while (frameCount < FRAMES) begin
         @(posedge clk7);
         sinceReset++;
         lineNo = (sinceReset / `ULA_H_TOTAL) % `ULA_V_TOTAL;
         iorqN <= 1'b1;
         rdN   <= 1'b1;
         wrN   <= 1'b1;
         ear   <= 1'($random(seed));
         kbd   <= 5'($random(seed));
         pick  = $unsigned($random(seed)) % 64;
         addr  = 16'($random(seed));
         case (pick)
            0: begin
               // Keep the border steady over the checked lines
               if (lineNo < 190 || lineNo > 244) begin
                  addr[0] = 1'b0;
                  a     <= addr;
                  din   <= 8'($random(seed));
                  iorqN <= 1'b0;
                  wrN   <= 1'b0;
               end
            end
            1, 2: begin
               addr[0] = 1'b0;
               a     <= addr;
               iorqN <= 1'b0;
               rdN   <= 1'b0;
            end
            3: begin
               addr[0] = 1'b1;
               a     <= addr;
               iorqN <= 1'b0;
               rdN   <= 1'b0;
            end
            default: begin
               a <= addr;
            end
         endcase
      end

      @(negedge clk7);
      if (UUT.chk.failCount == 0) begin
         $display("Simulation PASSED");
         $finish;
      end else begin
         $display("Simulation FAILED");
         $fatal(1, "checks failed");
      end
   end

endmodule

/* tests/ula_checker.sv */
`timescale 1ns/1ns

`include "ula_config.svh"

module ulaChecker
   import ulaPkg::*;
(
   input logic        clk7,
   input logic        rst_n,
   input logic [15:0] a,
   input logic        iorqN,
   input logic        rdN,
   input logic        wrN,
   input byteT        din,
   input byteT        dout,
   input vramAddr     va,
   input logic        ear,
   input logic [4:0]  kbd,
   input logic        mic,
   input logic        spk,
   input colour3      r,
   input colour3      g,
   input colour3      b,
   input logic        hsync,
   input logic        vsync,
   input logic        intN
);

   hCount       refH;
   vCount       refV;
   logic [4:0]  refFrame;
   colour3      refBorder;
   colour3      lineBorder;
   logic        refMic;
   logic        refSpk;
   logic        evenPort;
   logic        busWrite;
   byteT        expDout;
   logic        inPaperWin;
   logic        inBorderWin;
   logic        fetchWin;
   logic [4:0]  fetchCol;
   vramAddr     expVa;
   logic [4:0]  col;
   logic [2:0]  idx;
   logic        showInk;
   logic [3:0]  expIgrb;
   logic [2:0]  lvl;
   logic [8:0]  expPixel;
   logic [8:0]  borderPixel;
   logic [8:0]  outPixel;
   int          failCount = 0;
   string       failTest;
   logic [15:0] failExp;
   logic [15:0] failAct;

   task automatic recordFail(input string name, input logic [15:0] expV,
                             input logic [15:0] actV);
      failTest = name;
      failExp  = expV;
      failAct  = actV;
      failCount++;
   endtask

   ///////////////////////////////////////////////////////////////////////
   // Reference raster, frame and port state
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         refH     <= '0;
         refV     <= '0;
         refFrame <= '0;
      end else begin
         refH <= (refH == 447) ? 9'd0 : refH + 1'b1;
         if (refH == 447) begin
            refV <= (refV == 311) ? 9'd0 : refV + 1'b1;
         end
         if (refV == 248 && refH == 0) begin
            refFrame <= refFrame + 1'b1;
         end
      end
   end

   assign evenPort = !a[0] && (a[7:0] != 8'hF4);
   assign busWrite = !iorqN && !wrN && evenPort;

   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         refBorder  <= 3'd2;
         lineBorder <= 3'd2;
         refMic     <= 1'b0;
         refSpk     <= 1'b0;
      end else begin
         if (busWrite) begin
            refBorder <= din[2:0];
            refMic    <= din[3];
            refSpk    <= din[4];
         end
         // Border seen on a line is the one held when it began
         if (refH == 0) begin
            lineBorder <= refBorder;
         end
      end
   end

   // Expected read data and pixel colour
   always_comb begin
      expDout     = (!iorqN && !rdN && evenPort) ? {1'b1, ear ^ refSpk, 1'b1, kbd} : 8'hFF;
      inPaperWin  = (refV < 192) && (refH >= 13) && (refH <= 268);
      inBorderWin = (refV >= 200) && (refV <= 240);
      // Second half of each 16-clock cell fetches, column from the last load at hc[2:0] == 3
      fetchWin    = (refV < 192) && (refH < 256) && refH[3];
      fetchCol    = 5'((refH - 9'd4) >> 3);
      expVa       = refH[1] ? {1'b0, 3'b110, refV[7:3], fetchCol} :
                              {1'b0, refV[7:6], refV[2:0], refV[5:3], fetchCol};
      col         = 5'((refH - 9'd13) >> 3);
      idx         = 3'(refH - 9'd13);
      showInk     = (idx < 4) ^ (col[4] & refFrame[4]);
      expIgrb     = {col[3], showInk ? col[2:0] : refV[5:3]};
      lvl         = expIgrb[3] ? 3'd7 : 3'd5;
      expPixel    = {expIgrb[2] ? lvl : 3'd0, expIgrb[1] ? lvl : 3'd0,
                     expIgrb[0] ? lvl : 3'd0};
      borderPixel = {lineBorder[2] ? 3'd5 : 3'd0, lineBorder[1] ? 3'd5 : 3'd0,
                     lineBorder[0] ? 3'd5 : 3'd0};
      outPixel    = {g, r, b};
   end

   ///////////////////////////////////////////////////////////////////////
   // Assertions
   ///////////////////////////////////////////////////////////////////////

   assert property (@(posedge clk7) disable iff (!rst_n)
         hsync == !((refH >= 344) && (refH <= 375)))
      else begin
         recordFail("hsync", 16'(!$sampled((refH >= 344) && (refH <= 375))),
                    16'($sampled(hsync)));
         $error("hsync low at the wrong position");
      end

   assert property (@(posedge clk7) disable iff (!rst_n)
         vsync == !((refV >= 248) && (refV <= 251)))
      else begin
         recordFail("vsync", 16'(!$sampled((refV >= 248) && (refV <= 251))),
                    16'($sampled(vsync)));
         $error("vsync low on the wrong line");
      end

   assert property (@(posedge clk7) disable iff (!rst_n)
         intN == !((refV == 248) && (refH <= 31)))
      else begin
         recordFail("interrupt", 16'(!$sampled((refV == 248) && (refH <= 31))),
                    16'($sampled(intN)));
         $error("frame interrupt at the wrong position");
      end

   assert property (@(posedge clk7) disable iff (!rst_n)
         fetchWin |-> (va == expVa))
      else begin
         recordFail("vram address", 16'($sampled(expVa)), 16'($sampled(va)));
         $error("video RAM address wrong during a fetch");
      end

   assert property (@(posedge clk7) disable iff (!rst_n)
         inPaperWin |-> (outPixel == expPixel))
      else begin
         recordFail("paper", 16'($sampled(expPixel)), 16'($sampled(outPixel)));
         $error("paper pixel colour wrong");
      end

   assert property (@(posedge clk7) disable iff (!rst_n)
         inBorderWin |-> (outPixel == borderPixel))
      else begin
         recordFail("border", 16'($sampled(borderPixel)), 16'($sampled(outPixel)));
         $error("border pixel colour wrong");
      end

   assert property (@(posedge clk7) disable iff (!rst_n)
         {mic, spk} == {refMic, refSpk})
      else begin
         recordFail("port write", 16'($sampled({refMic, refSpk})), 16'($sampled({mic, spk})));
         $error("mic or spk does not follow the last port write");
      end

   assert property (@(posedge clk7) disable iff (!rst_n) dout == expDout)
      else begin
         recordFail("port read", 16'($sampled(expDout)), 16'($sampled(dout)));
         $error("read data wrong");
      end

endmodule
